/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire [cpuPkg::xlen-1:0] opA,
	input wire [cpuPkg::xlen-1:0] opB,
	input wire [4:0] aluOp,
	input wire [4:0] shamt,
	output logic [cpuPkg::xlen-1:0] result,
	output logic notEqual,
	output logic lessThan
);

	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd: result = opA + opB;
			cpuPkg::aluSub: result = opA - opB;
			cpuPkg::aluAnd: result = opA & opB;
			cpuPkg::aluOr: result = opA | opB;
			cpuPkg::aluSll: result = opA << shamt;
			cpuPkg::aluSra: result = $signed(opA) >>> shamt;  // sign fill
			default: result = opA + opB;
		endcase
	end

	// branch flags, signed compare
	assign notEqual = opA != opB;
	assign lessThan = $signed(opA) < $signed(opB);

endmodule

`default_nettype wire

/* hw/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
	input wire cpuPkg::instrWord instr,
	output cpuPkg::ctrlSignals ctrl,
	output logic [cpuPkg::regAddrWidth-1:0] rA,
	output logic [cpuPkg::regAddrWidth-1:0] rB,
	output logic [cpuPkg::regAddrWidth-1:0] writeReg,
	output logic [cpuPkg::xlen-1:0] immediate
);

	logic isBranch;

	always_comb begin
		ctrl = '0;  // unknown opcodes decode as a bubble
		case (instr.r.opcode)
			cpuPkg::opRType: begin
				ctrl.regWe = 1'b1;
				ctrl.aluOp = instr.r.aluOp;
			end
			cpuPkg::opAddi: begin
				ctrl.regWe = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::opLw: begin
				ctrl.regWe = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::opSw: begin
				ctrl.memWe = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.readBFromRd = 1'b1;
			end
			cpuPkg::opBne: begin
				ctrl.isBne = 1'b1;
				ctrl.aluOp = cpuPkg::aluSub;
			end
			cpuPkg::opBlt: begin
				ctrl.isBlt = 1'b1;
				ctrl.aluOp = cpuPkg::aluSub;
			end
			cpuPkg::opJ: ctrl.isJ = 1'b1;
			cpuPkg::opJal: begin
				ctrl.isJal = 1'b1;
				ctrl.regWe = 1'b1;
			end
			cpuPkg::opJr: ctrl.isJr = 1'b1;
			default: ctrl = '0;
		endcase
	end

	assign isBranch = ctrl.isBne | ctrl.isBlt;

	// branches compare rd against rs, jr jumps to rd
	assign rA = (isBranch || ctrl.isJr) ? instr.r.rd :
		(ctrl.isJ || ctrl.isJal) ? '0 : instr.r.rs;  // r0 keeps jumps out of hazards
	assign rB = ctrl.readBFromRd ? instr.r.rd : isBranch ? instr.r.rs : instr.r.rt;
	assign writeReg = ctrl.isJal ? cpuPkg::linkReg : instr.r.rd;
	assign immediate = {{(cpuPkg::xlen-17){instr.i.imm[16]}}, instr.i.imm};

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	////////////////////
	// widths
	localparam int xlen = 32;
	localparam int pcWidth = 12;
	localparam int dataAddrWidth = 12;
	localparam int regAddrWidth = 5;
	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;  // jal destination

	////////////////////
	// opcodes, bits 31..27
	localparam logic [4:0] opRType = 5'b00000;
	localparam logic [4:0] opJ     = 5'b00001;
	localparam logic [4:0] opBne   = 5'b00010;
	localparam logic [4:0] opJal   = 5'b00011;
	localparam logic [4:0] opJr    = 5'b00100;
	localparam logic [4:0] opAddi  = 5'b00101;
	localparam logic [4:0] opBlt   = 5'b00110;
	localparam logic [4:0] opSw    = 5'b00111;
	localparam logic [4:0] opLw    = 5'b01000;

	// alu op field of r-type
	localparam logic [4:0] aluAdd = 5'b00000;
	localparam logic [4:0] aluSub = 5'b00001;
	localparam logic [4:0] aluAnd = 5'b00010;
	localparam logic [4:0] aluOr  = 5'b00011;
	localparam logic [4:0] aluSll = 5'b00100;
	localparam logic [4:0] aluSra = 5'b00101;

	// operand source in execute
	localparam logic [1:0] bypassRf = 2'd0;
	localparam logic [1:0] bypassM  = 2'd1;
	localparam logic [1:0] bypassW  = 2'd2;

	////////////////////
	// instruction word
	typedef struct packed {
		logic [4:0] opcode;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [4:0] shamt;
		logic [4:0] aluOp;
		logic [1:0] pad;
	} rFields;

	typedef struct packed {
		logic [4:0] opcode;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs;
		logic [16:0] imm;  // signed
	} iFields;

	typedef union packed {
		rFields r;
		iFields i;
	} instrWord;  // jump target is raw bits 26..0

	typedef struct packed {
		logic regWe;
		logic memWe;
		logic memToReg;
		logic aluSrcImm;
		logic isBne;
		logic isBlt;
		logic isJ;
		logic isJal;
		logic isJr;
		logic [4:0] aluOp;
		logic readBFromRd;  // sw data comes from rd
	} ctrlSignals;

	////////////////////
	// pipeline registers
	typedef struct packed {
		logic [pcWidth-1:0] pc;
		instrWord instr;
		logic valid;
	} fdStage;

	typedef struct packed {
		ctrlSignals ctrl;
		logic [pcWidth-1:0] pc;
		logic [xlen-1:0] opA;
		logic [xlen-1:0] opB;
		logic [xlen-1:0] imm;
		logic [pcWidth-1:0] target;
		logic [4:0] shamt;
		logic [regAddrWidth-1:0] writeReg;
		logic [regAddrWidth-1:0] srcA;
		logic [regAddrWidth-1:0] srcB;
		logic valid;
	} dxStage;

	typedef struct packed {
		ctrlSignals ctrl;
		logic [xlen-1:0] aluResult;
		logic [xlen-1:0] storeData;
		logic [regAddrWidth-1:0] writeReg;
		logic [regAddrWidth-1:0] srcB;
		logic valid;
	} xmStage;

	typedef struct packed {
		logic regWe;
		logic memToReg;
		logic [xlen-1:0] aluResult;  // PC+1 for jal
		logic [xlen-1:0] loadData;
		logic [regAddrWidth-1:0] writeReg;
		logic valid;
	} mwStage;

	////////////////////
	// observation and hazard records
	typedef struct packed {
		logic valid;
		logic [regAddrWidth-1:0] regIdx;
		logic [xlen-1:0] data;
	} wbEvent;

	typedef struct packed {
		logic valid;
		logic [dataAddrWidth-1:0] addr;
		logic [xlen-1:0] data;
	} storeEvent;

	typedef struct packed {
		logic [1:0] aSel;
		logic [1:0] bSel;
		logic storeFromW;
	} bypassSel;

endpackage

`default_nettype wire

/* hw/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
	input wire clock,
	input wire we,
	input wire [cpuPkg::dataAddrWidth-1:0] addr,
	input wire [cpuPkg::xlen-1:0] wData,
	output logic [cpuPkg::xlen-1:0] rData
);

	logic [cpuPkg::xlen-1:0] mem [0:(2**cpuPkg::dataAddrWidth)-1];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wData;
		end
	end

	assign rData = mem[addr];  // async read

endmodule

`default_nettype wire

/* hw/pipeControl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeControl (
	input wire [cpuPkg::regAddrWidth-1:0] rA,
	input wire [cpuPkg::regAddrWidth-1:0] rB,
	input wire usesB,
	input wire cpuPkg::dxStage dx,
	input wire cpuPkg::xmStage xm,
	input wire [cpuPkg::regAddrWidth-1:0] mwReg,
	input wire mwWe,
	input wire redirect,
	output logic stall,
	output logic flush,
	output cpuPkg::bypassSel bypass
);

	logic loadUse;
	logic mWrites;
	logic wWrites;

	// closest producer wins, r0 never forwards
	function automatic logic [1:0] pickSource(
		input logic [cpuPkg::regAddrWidth-1:0] src,
		input logic [cpuPkg::regAddrWidth-1:0] mReg,
		input logic mHit,
		input logic [cpuPkg::regAddrWidth-1:0] wReg,
		input logic wHit
	);
		if (src == '0) return cpuPkg::bypassRf;
		if (mHit && mReg == src) return cpuPkg::bypassM;
		if (wHit && wReg == src) return cpuPkg::bypassW;
		return cpuPkg::bypassRf;
	endfunction

	assign mWrites = xm.valid && xm.ctrl.regWe && xm.writeReg != '0;
	assign wWrites = mwWe && mwReg != '0;

	////////////////////
	// load-use, sw data is left to the WM path
	assign loadUse = dx.valid && dx.ctrl.memToReg && dx.writeReg != '0 &&
		(dx.writeReg == rA || (usesB && dx.writeReg == rB));
	assign stall = loadUse && !redirect;  // redirect kills the waiting instruction anyway
	assign flush = redirect;

	////////////////////
	// bypass selects
	assign bypass.aSel = pickSource(dx.srcA, xm.writeReg, mWrites, mwReg, wWrites);
	assign bypass.bSel = pickSource(dx.srcB, xm.writeReg, mWrites, mwReg, wWrites);
	assign bypass.storeFromW = xm.valid && xm.ctrl.memWe && wWrites && mwReg == xm.srcB;

endmodule

`default_nettype wire

/* hw/processor.sv */
`timescale 1ns/1ps
`default_nettype none

module processor (
	input wire clock,
	input wire rstN,
	output logic [cpuPkg::pcWidth-1:0] imemAddr,
	input wire cpuPkg::instrWord imemData,
	output cpuPkg::wbEvent wb,
	output cpuPkg::storeEvent store
);

	logic [cpuPkg::pcWidth-1:0] pc, pcNext, branchTarget, linkPc;
	cpuPkg::fdStage fd, fdNext;
	cpuPkg::dxStage dx, dxNext;
	cpuPkg::xmStage xm, xmNext;
	cpuPkg::mwStage mw, mwNext;
	cpuPkg::ctrlSignals decCtrl;
	cpuPkg::bypassSel bypass;
	logic [cpuPkg::regAddrWidth-1:0] decRA, decRB, decWReg;
	logic [cpuPkg::xlen-1:0] decImm, rfA, rfB;
	logic [cpuPkg::xlen-1:0] fwdA, fwdB, aluB, aluResult, wbData, storeData, loadData;
	logic stall, flush, redirect, takeBranch, usesB, notEqual, lessThan;

	////////////////////
	// decode
	control decoder (.instr(fd.instr), .ctrl(decCtrl), .rA(decRA), .rB(decRB),
		.writeReg(decWReg), .immediate(decImm));

	regFile registers (.clock(clock), .rstN(rstN), .we(wb.valid), .wReg(mw.writeReg),
		.wData(wbData), .rA(decRA), .rB(decRB), .dataA(rfA), .dataB(rfB));

	// port B only matters to the hazard check when it feeds the alu
	assign usesB = ~decCtrl.aluSrcImm & ~(decCtrl.isJ | decCtrl.isJal | decCtrl.isJr);

	pipeControl hazards (.rA(decRA), .rB(decRB), .usesB(usesB), .dx(dx), .xm(xm),
		.mwReg(mw.writeReg), .mwWe(wb.valid), .redirect(redirect), .stall(stall),
		.flush(flush), .bypass(bypass));

	////////////////////
	// execute
	always_comb begin
		case (bypass.aSel)
			cpuPkg::bypassM: fwdA = xm.aluResult;
			cpuPkg::bypassW: fwdA = wbData;
			default: fwdA = dx.opA;
		endcase
		case (bypass.bSel)
			cpuPkg::bypassM: fwdB = xm.aluResult;
			cpuPkg::bypassW: fwdB = wbData;
			default: fwdB = dx.opB;
		endcase
	end

	assign aluB = dx.ctrl.aluSrcImm ? dx.imm : fwdB;

	alu execAlu (.opA(fwdA), .opB(aluB), .aluOp(dx.ctrl.aluOp), .shamt(dx.shamt),
		.result(aluResult), .notEqual(notEqual), .lessThan(lessThan));

	assign takeBranch = (dx.ctrl.isBne & notEqual) | (dx.ctrl.isBlt & lessThan);
	assign redirect = dx.valid & (takeBranch | dx.ctrl.isJ | dx.ctrl.isJal | dx.ctrl.isJr);
	assign linkPc = dx.pc + 1'b1;
	assign branchTarget = linkPc + dx.imm[cpuPkg::pcWidth-1:0];

	always_comb begin
		if (redirect) begin
			if (takeBranch) pcNext = branchTarget;
			else if (dx.ctrl.isJr) pcNext = fwdA[cpuPkg::pcWidth-1:0];
			else pcNext = dx.target;
		end else if (stall) begin
			pcNext = pc;
		end else begin
			pcNext = pc + 1'b1;
		end
	end

	////////////////////
	// memory and writeback
	assign storeData = bypass.storeFromW ? wbData : xm.storeData;  // WM path
	assign store.valid = xm.valid & xm.ctrl.memWe;
	assign store.addr = xm.aluResult[cpuPkg::dataAddrWidth-1:0];
	assign store.data = storeData;

	dataMemory dmem (.clock(clock), .we(store.valid), .addr(store.addr),
		.wData(storeData), .rData(loadData));

	assign wbData = mw.memToReg ? mw.loadData : mw.aluResult;
	assign wb.valid = mw.valid & mw.regWe;
	assign wb.regIdx = mw.writeReg;
	assign wb.data = wbData;
	assign imemAddr = pc;

	////////////////////
	// stage register inputs
	always_comb begin
		fdNext = fd;  // stall holds decode
		if (flush) begin
			fdNext.valid = 1'b0;
		end else if (!stall) begin
			fdNext.pc = pc;
			fdNext.instr = imemData;
			fdNext.valid = 1'b1;
		end

		dxNext.ctrl = fd.valid ? decCtrl : '0;
		dxNext.pc = fd.pc;
		dxNext.opA = rfA;
		dxNext.opB = rfB;
		dxNext.imm = decImm;
		dxNext.target = fd.instr[cpuPkg::pcWidth-1:0];  // 27-bit target spans the whole pc
		dxNext.shamt = fd.instr.r.shamt;
		dxNext.writeReg = decWReg;
		dxNext.srcA = decRA;
		dxNext.srcB = decRB;
		dxNext.valid = fd.valid;
		if (flush || stall) begin
			dxNext.ctrl = '0;  // bubble
			dxNext.valid = 1'b0;
		end

		xmNext.ctrl = dx.ctrl;
		xmNext.aluResult = dx.ctrl.isJal ? {{(cpuPkg::xlen-cpuPkg::pcWidth){1'b0}}, linkPc}
			: aluResult;
		xmNext.storeData = fwdB;
		xmNext.writeReg = dx.writeReg;
		xmNext.srcB = dx.srcB;
		xmNext.valid = dx.valid;

		mwNext.regWe = xm.ctrl.regWe;
		mwNext.memToReg = xm.ctrl.memToReg;
		mwNext.aluResult = xm.aluResult;
		mwNext.loadData = loadData;
		mwNext.writeReg = xm.writeReg;
		mwNext.valid = xm.valid;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			pc <= '0;
			fd.valid <= 1'b0;
			dx.valid <= 1'b0;
			dx.ctrl <= '0;
			xm.valid <= 1'b0;
			xm.ctrl <= '0;
			mw.valid <= 1'b0;
			mw.regWe <= 1'b0;
			mw.memToReg <= 1'b0;
		end else begin
			pc <= pcNext;
			fd <= fdNext;
			dx <= dxNext;
			xm <= xmNext;
			mw <= mwNext;
		end
	end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire clock,
	input wire rstN,
	input wire we,
	input wire [cpuPkg::regAddrWidth-1:0] wReg,
	input wire [cpuPkg::xlen-1:0] wData,
	input wire [cpuPkg::regAddrWidth-1:0] rA,
	input wire [cpuPkg::regAddrWidth-1:0] rB,
	output logic [cpuPkg::xlen-1:0] dataA,
	output logic [cpuPkg::xlen-1:0] dataB
);

	logic [cpuPkg::xlen-1:0] regs [0:31];  // entry 0 is never written

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wReg != '0) begin
			regs[wReg] <= wData;
		end
	end

	// same-cycle write shows up on the read side
	always_comb begin
		if (rA == '0) dataA = '0;
		else if (we && wReg == rA) dataA = wData;
		else dataA = regs[rA];

		if (rB == '0) dataB = '0;
		else if (we && wReg == rB) dataB = wData;
		else dataB = regs[rB];
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tbProcessor -f tb.f -o simProcessor > build.log 2>&1 &&
./obj_dir/simProcessor > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
grep -q "^sim passed$" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

/* tb.f */
+incdir+tb
hw/cpuPkg.sv
hw/regFile.sv
hw/control.sv
hw/alu.sv
hw/pipeControl.sv
hw/dataMemory.sv
hw/processor.sv
tb/tbProcessor.sv

/* tb/programTable.svh */
`ifndef programTableSvh
`define programTableSvh

////////////////////
// test program, one word per address
localparam int programLength = 40;

logic [31:0] programWords [programLength] = '{
	32'h2840_0035,  // 0  addi r1, r0, 0x35
	32'h2881_FFFA,  // 1  addi r2, r0, -6
	32'h00C2_2000,  // 2  add r3, r1, r2
	32'h0106_1004,  // 3  sub r4, r3, r1
	32'h0148_3008,  // 4  and r5, r4, r3
	32'h018A_100C,  // 5  or r6, r5, r1
	32'h01CC_0210,  // 6  sll r7, r6, 4
	32'h0208_0094,  // 7  sra r8, r4, 1
	32'h2A40_0100,  // 8  addi r9, r0, 0x100
	32'h028E_8000,  // 9  add r10, r7, r8
	32'h3A92_0003,  // 10 sw r10, 3(r9)
	32'h42D2_0003,  // 11 lw r11, 3(r9)
	32'h0316_A000,  // 12 add r12, r11, r10
	32'h4352_0003,  // 13 lw r13, 3(r9)
	32'h3B52_0005,  // 14 sw r13, 5(r9)
	32'h10C6_0002,  // 15 bne r3, r3, +2
	32'h2BC0_0001,  // 16 addi r15, r0, 1
	32'h13C0_0002,  // 17 bne r15, r0, +2
	32'h2C00_07FF,  // 18 addi r16, r0, 0x7ff
	32'h2C00_07FE,  // 19 addi r16, r0, 0x7fe
	32'h3106_0002,  // 20 blt r4, r3, +2
	32'h2C40_0111,  // 21 addi r17, r0, 0x111
	32'h2C40_0222,  // 22 addi r17, r0, 0x222
	32'h30C8_0005,  // 23 blt r3, r4, +5
	32'h2C80_0333,  // 24 addi r18, r0, 0x333
	32'h0800_001C,  // 25 j 28
	32'h2CC0_00AA,  // 26 addi r19, r0, 0xaa
	32'h2CC0_00BB,  // 27 addi r19, r0, 0xbb
	32'h1800_0020,  // 28 jal 32
	32'h2D00_0444,  // 29 addi r20, r0, 0x444
	32'h0800_0024,  // 30 j 36
	32'h2D40_0555,  // 31 addi r21, r0, 0x555
	32'h2D80_0666,  // 32 addi r22, r0, 0x666
	32'h27C0_0000,  // 33 jr r31
	32'h2DC0_0777,  // 34 addi r23, r0, 0x777
	32'h2DC0_0778,  // 35 addi r23, r0, 0x778
	32'h2800_05A5,  // 36 addi r0, r0, 0x5a5
	32'h0601_2000,  // 37 add r24, r0, r18
	32'h064C_0000,  // 38 add r25, r6, r0
	32'h0800_0027   // 39 j 39
};

////////////////////
// expected writebacks in order: valid, register, data
localparam int wbCount = 21;

cpuPkg::wbEvent wbTable [wbCount] = '{
	{1'b1, 5'd1, 32'h0000_0035}, {1'b1, 5'd2, 32'hFFFF_FFFA},
	{1'b1, 5'd3, 32'h0000_002F}, {1'b1, 5'd4, 32'hFFFF_FFFA},
	{1'b1, 5'd5, 32'h0000_002A}, {1'b1, 5'd6, 32'h0000_003F},
	{1'b1, 5'd7, 32'h0000_03F0}, {1'b1, 5'd8, 32'hFFFF_FFFD},
	{1'b1, 5'd9, 32'h0000_0100}, {1'b1, 5'd10, 32'h0000_03ED},
	{1'b1, 5'd11, 32'h0000_03ED}, {1'b1, 5'd12, 32'h0000_07DA},
	{1'b1, 5'd13, 32'h0000_03ED}, {1'b1, 5'd15, 32'h0000_0001},
	{1'b1, 5'd18, 32'h0000_0333}, {1'b1, 5'd31, 32'h0000_001D},  // link is 28 + 1
	{1'b1, 5'd22, 32'h0000_0666}, {1'b1, 5'd20, 32'h0000_0444},
	{1'b1, 5'd0, 32'h0000_05A5}, {1'b1, 5'd24, 32'h0000_0333},
	{1'b1, 5'd25, 32'h0000_003F}
};

string wbNames [wbCount] = '{
	"addi positive imm", "addi negative imm", "add mx and wx",
	"sub mx and write-through", "and", "or",
	"sll", "sra", "addi store base",
	"add store value", "lw after sw", "add after load-use stall",
	"lw for wm path", "addi after bne not taken", "addi after blt not taken",
	"jal link", "subroutine body", "addi after jr return",
	"addi to r0", "add r0 on port a", "add r0 on port b"
};

////////////////////
// expected stores in order: valid, address, data
localparam int storeCount = 2;

cpuPkg::storeEvent storeTable [storeCount] = '{
	{1'b1, 12'h103, 32'h0000_03ED},
	{1'b1, 12'h105, 32'h0000_03ED}  // data only right through the wm path
};

string storeNames [storeCount] = '{"sw of mx value", "sw of loaded value"};

`endif

/* tb/tbProcessor.sv */
`timescale 1ns/1ps
`default_nettype none

module tbProcessor;

	localparam int resetCycles = 8;
	localparam int strobeTimeout = 50;  // cycles
	localparam int quietCycles = 40;
	localparam int randomSeed = 59731;
	localparam int imemDepth = 2 ** cpuPkg::pcWidth;

	logic clock;
	logic rstN;
	logic [cpuPkg::pcWidth-1:0] imemAddr;
	cpuPkg::instrWord imemData;
	cpuPkg::wbEvent wb;
	cpuPkg::storeEvent store;

	logic [31:0] imem [0:imemDepth-1];
	int wbIdx;
	int storeIdx;

	`include "programTable.svh"

	processor dut0 (
		.clock(clock),
		.rstN(rstN),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wb(wb),
		.store(store)
	);

	always #4 clock = ~clock;

	// instruction memory model, driven for the new pc
	always @(posedge clock) begin
		#1;
		// the final self jump lets two flushed fetches run past the end
		if (rstN) begin
			assert (imemAddr < programLength + 2) else
				abortRun($sformatf("fetch address %0d runs past the end of the program",
					imemAddr));
		end
		imemData = imem[imemAddr];
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic waitForStrobe();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!wb.valid && !store.valid) begin
			cycles++;
			assert (cycles < strobeTimeout) else
				abortRun($sformatf("no writeback or store strobe within %0d cycles",
					strobeTimeout));
			@(negedge clock);
		end
	endtask

	task automatic checkWriteback();
		assert (wbIdx < wbCount) else
			abortRun($sformatf("unexpected writeback of %h to r%0d", wb.data, wb.regIdx));
		assert (wb == wbTable[wbIdx]) else
			abortRun($sformatf("[ERROR] %s: expected r%0d = %h, actual r%0d = %h",
				wbNames[wbIdx], wbTable[wbIdx].regIdx, wbTable[wbIdx].data,
				wb.regIdx, wb.data));
		wbIdx++;
	endtask

	task automatic checkStore();
		assert (storeIdx < storeCount) else
			abortRun($sformatf("unexpected store of %h to %h", store.data, store.addr));
		assert (store == storeTable[storeIdx]) else
			abortRun($sformatf("[ERROR] %s: expected [%h] = %h, actual [%h] = %h",
				storeNames[storeIdx], storeTable[storeIdx].addr, storeTable[storeIdx].data,
				store.addr, store.data));
		storeIdx++;
	endtask

	initial begin
		int seedResult;
		seedResult = $urandom(randomSeed);
		clock = 1'b0;
		rstN = 1'b0;
		imemData = '0;
		wbIdx = 0;
		storeIdx = 0;
		for (int i = 0; i < imemDepth; i++) begin
			if (i < programLength) imem[i] = programWords[i];
			else imem[i] = $urandom();  // past the final self jump
		end

		////////////////////
		// no strobes during reset
		repeat (resetCycles) begin
			@(posedge clock);
			#1;
			assert (!wb.valid && !store.valid) else
				abortRun("a writeback or store strobe was high during reset");
		end
		rstN = 1'b1;

		// walk both event tables
		// a writeback and a store may share a cycle
		while (wbIdx < wbCount || storeIdx < storeCount) begin
			waitForStrobe();
			if (wb.valid) checkWriteback();
			if (store.valid) checkStore();
		end

		repeat (quietCycles) begin
			@(negedge clock);
			assert (!wb.valid && !store.valid) else
				abortRun($sformatf("strobe after the last expected event (wb %0b, store %0b)",
					wb.valid, store.valid));
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
